//--- sim.f
+incdir+tests
logic/wdt_pkg.sv
logic/wdt_reg_pkg.sv
logic/wdt_timer.sv
logic/wdt_unit.sv
logic/wdt_regs.sv
logic/wdt_subsys.sv
tests/wdt_tb.sv

//--- Makefile
# Verilator build and run of the watchdog testbench

VERILATOR ?= verilator
TOP       ?= wdt_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Fails unless the pass message appears in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/wdt_tb_table.svh
`ifndef WDT_TB_TABLE_SVH
`define WDT_TB_TABLE_SVH

// Columns: name, mode, t1 period, t2 period, service t1, random periods,
// expected t1_irq pulses, t2_irq pulses, fatal, status word
task automatic fill_table();
    // Both timers run on their own and each raises its own timeout
    row_name[0] = "independent";
    rows[0] = '{mode: mode_indep, t1_period: 32'd20, t2_period: 32'd35,
                service: 1'b1, rand_per: 1'b0,
                exp_t1_irq: 1'b1, exp_t2_irq: 1'b1, exp_fatal: 1'b0,
                exp_status: 3'b011};

    // Timer1 serviced before timer2 can expire
    // t1 period is long so timer1 does not expire again during the check
    row_name[1] = "cascade_serviced";
    rows[1] = '{mode: mode_cascade, t1_period: 32'd200, t2_period: 32'd40,
                service: 1'b1, rand_per: 1'b0,
                exp_t1_irq: 1'b1, exp_t2_irq: 1'b0, exp_fatal: 1'b0,
                exp_status: 3'b000};

    // Nobody services timer1, timer2 escalates to fatal
    row_name[2] = "cascade_fatal";
    rows[2] = '{mode: mode_cascade, t1_period: 32'd15, t2_period: 32'd30,
                service: 1'b0, rand_per: 1'b0,
                exp_t1_irq: 1'b1, exp_t2_irq: 1'b0, exp_fatal: 1'b1,
                exp_status: 3'b111};

    // Periodic restarts keep timer1 from ever expiring
    row_name[3] = "restart_hold";
    rows[3] = '{mode: mode_hold, t1_period: 32'd30, t2_period: 32'd40,
                service: 1'b0, rand_per: 1'b0,
                exp_t1_irq: 1'b0, exp_t2_irq: 1'b0, exp_fatal: 1'b0,
                exp_status: 3'b000};

    // Same as the first row with seeded random periods
    row_name[4] = "random_independent";
    rows[4] = '{mode: mode_indep, t1_period: 32'd0, t2_period: 32'd0,
                service: 1'b1, rand_per: 1'b1,
                exp_t1_irq: 1'b1, exp_t2_irq: 1'b1, exp_fatal: 1'b0,
                exp_status: 3'b011};
endtask

`endif

//--- tests/wdt_tb.sv
`timescale 1ns/1ps

module wdt_tb;

    localparam int n_rows = 5;
    // Extra cycles allowed beyond the period plus 2 bound
    localparam int margin = 8;

    // Row modes
    localparam logic [1:0] mode_indep   = 2'd0;
    localparam logic [1:0] mode_cascade = 2'd1;
    localparam logic [1:0] mode_hold    = 2'd2;

    typedef struct packed {
        logic [1:0]  mode;
        logic [31:0] t1_period;
        logic [31:0] t2_period;
        logic        service;
        logic        rand_per;
        logic        exp_t1_irq;
        logic        exp_t2_irq;
        logic        exp_fatal;
        logic [2:0]  exp_status;
    } row_t;

    logic clk;
    logic rst_b;
    wdt_reg_pkg::reg_req_t req;
    wdt_reg_pkg::reg_rsp_t rsp;
    logic t1_irq;
    logic t2_irq;
    logic fatal;

    row_t  rows [n_rows];
    string row_name [n_rows];

    int errors;
    int n_pass;
    int n_fail;
    int seed;
    // Pulses seen since the last reset
    int t1_irq_cnt;
    int t2_irq_cnt;
    // Last response
    logic [31:0] rdata;
    logic        rerr;

    `include "wdt_tb_table.svh"

    wdt_subsys wdt_subsys_inst (
        .clk    (clk),
        .rst_b  (rst_b),
        .req    (req),
        .rsp    (rsp),
        .t1_irq (t1_irq),
        .t2_irq (t2_irq),
        .fatal  (fatal)
    );

    always #20 clk = ~clk;

    // Count irq pulses on the falling edge where they are stable
    always @(negedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t1_irq_cnt <= 0;
            t2_irq_cnt <= 0;
        end else begin
            if (t1_irq) t1_irq_cnt <= t1_irq_cnt + 1;
            if (t2_irq) t2_irq_cnt <= t2_irq_cnt + 1;
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        rst_b = 1'b0;
        req   = '0;
        repeat (16) @(negedge clk);
        rst_b = 1'b1;
        @(negedge clk);
    endtask

    // One request cycle, then poll for the response
    task automatic reg_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata);
        int n;
        n = 0;
        @(negedge clk);
        req.valid = 1'b1;
        req.write = wr;
        req.addr  = addr;
        req.wdata = wdata;
        @(negedge clk);
        req = '0;
        while (!rsp.valid && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!rsp.valid) begin
            $display("No response to the register access at address %0d", addr);
            errors++;
        end else if (n != 0) begin
            // The response belongs in the cycle right after the request
            $display("ERR %0t: response to address %0d came %0d cycles late", $time, addr, n);
            errors++;
        end
        rdata = rsp.rdata;
        rerr  = rsp.err;
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] wdata);
        reg_access(1'b1, addr, wdata);
        // Writes answer with zero data and no error
        if (rdata !== 32'h0 || rerr !== 1'b0) begin
            $display("ERR %0t: write to address %0d answered %h err %b", $time, addr,
                     rdata, rerr);
            errors++;
        end
    endtask

    task automatic reg_read(input logic [3:0] addr);
        reg_access(1'b0, addr, 32'h0);
    endtask

    // which selects timer1 or timer2
    task automatic wait_irq(input int which, input int limit);
        int n;
        n = 0;
        while (((which == 1) ? t1_irq_cnt : t2_irq_cnt) == 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (((which == 1) ? t1_irq_cnt : t2_irq_cnt) == 0) begin
            $display("Timed out after %0d cycles waiting for t%0d_irq", limit, which);
            errors++;
        end
    endtask

    task automatic wait_fatal(input int limit);
        int n;
        n = 0;
        while (!fatal && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!fatal) begin
            $display("Timed out after %0d cycles waiting for fatal", limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        if (errors == start_err) begin
            $display("PASS %s", name);
            n_pass++;
        end else begin
            $display("FAIL %s", name);
            n_fail++;
        end
    endtask

    task automatic check_reset_values();
        int start_err;
        logic [31:0] exp;
        start_err = errors;
        apply_reset();
        if (t1_irq || t2_irq || fatal) begin
            $display("ERR %0t: irq or fatal high after reset", $time);
            errors++;
        end
        // Periods come up as all ones, ctrl and status as zero
        for (int a = 0; a < 6; a++) begin
            exp = (a >= 1 && a <= 4) ? 32'hffff_ffff : 32'h0;
            reg_read(a[3:0]);
            if (rdata !== exp || rerr !== 1'b0) begin
                $display("ERR %0t: address %0d read %h err %b, expected %h", $time, a, rdata,
                         rerr, exp);
                errors++;
            end
        end
        reg_read(4'd7);
        if (rerr !== 1'b1) begin
            $display("ERR %0t: read of address 7 gave no err", $time);
            errors++;
        end
        report_test("reset_values", start_err);
    endtask

    task automatic run_row(input int i);
        row_t r;
        int p1;
        int p2;
        int n;
        int start_err;
        r = rows[i];
        p1 = int'(r.t1_period);
        p2 = int'(r.t2_period);
        start_err = errors;
        if (r.rand_per) begin
            p1 = 5 + int'($unsigned($random(seed)) % 36);
            p2 = 5 + int'($unsigned($random(seed)) % 36);
        end
        apply_reset();
        reg_write(wdt_reg_pkg::addr_t1_lo, p1);
        reg_write(wdt_reg_pkg::addr_t1_hi, 32'h0);
        reg_write(wdt_reg_pkg::addr_t2_lo, p2);
        reg_write(wdt_reg_pkg::addr_t2_hi, 32'h0);
        case (r.mode)
            mode_indep: begin
                // Both enables and both restarts
                reg_write(wdt_reg_pkg::addr_ctrl, 32'hf);
                wait_irq(1, p1 + 2 + margin);
                wait_irq(2, p2 + 2 + margin);
            end
            mode_cascade: begin
                // Timer1 only, timer2 stays in cascade
                reg_write(wdt_reg_pkg::addr_ctrl, 32'h5);
                wait_irq(1, p1 + 2 + margin);
                if (r.service) begin
                    reg_write(wdt_reg_pkg::addr_status, 32'h1);
                    n = 0;
                    while (!fatal && n < 3 * p2) begin
                        @(negedge clk);
                        n++;
                    end
                    if (fatal) begin
                        $display("ERR %0t: fatal rose after timer1 was serviced", $time);
                        errors++;
                    end
                end else begin
                    wait_fatal(p2 + 2 + margin);
                end
            end
            default: begin
                // Restart roughly every 10 cycles for 200 cycles
                repeat (20) begin
                    reg_write(wdt_reg_pkg::addr_ctrl, 32'h5);
                    repeat (8) @(negedge clk);
                end
            end
        endcase
        if (t1_irq_cnt != int'(r.exp_t1_irq) || t2_irq_cnt != int'(r.exp_t2_irq)) begin
            $display("ERR %0t: irq pulses t1 %0d t2 %0d, expected %0d %0d", $time, t1_irq_cnt,
                     t2_irq_cnt, r.exp_t1_irq, r.exp_t2_irq);
            errors++;
        end
        if (fatal !== r.exp_fatal) begin
            $display("ERR %0t: fatal is %b, expected %b", $time, fatal, r.exp_fatal);
            errors++;
        end
        reg_read(wdt_reg_pkg::addr_status);
        if (rdata !== {29'd0, r.exp_status}) begin
            $display("ERR %0t: status read %h, expected %h", $time, rdata, r.exp_status);
            errors++;
        end
        // Clearing timer1 leaves the timer2 timeout alone
        if (r.mode == mode_indep && r.service) begin
            reg_write(wdt_reg_pkg::addr_status, 32'h1);
            reg_read(wdt_reg_pkg::addr_status);
            if (rdata !== {29'd0, r.exp_status & 3'b110}) begin
                $display("ERR %0t: status after t1 clear read %h", $time, rdata);
                errors++;
            end
        end
        // Fatal survives a write of all ones
        if (r.mode == mode_cascade && !r.service) begin
            reg_write(wdt_reg_pkg::addr_status, 32'h7);
            reg_read(wdt_reg_pkg::addr_status);
            if (rdata[2] !== 1'b1 || fatal !== 1'b1) begin
                $display("ERR %0t: fatal cleared by a status write", $time);
                errors++;
            end
        end
        report_test($sformatf("%s t1 %0d t2 %0d", row_name[i], p1, p2), start_err);
    endtask

    initial begin
        clk    = 1'b0;
        rst_b  = 1'b0;
        req    = '0;
        errors = 0;
        n_pass = 0;
        n_fail = 0;
        seed   = 32'hea2d_972e;
        fill_table();
        check_reset_values();
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (errors == 0 && n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- logic/wdt_subsys.sv
`timescale 1ns/1ps

// Watchdog subsystem top level
module wdt_subsys (
    input  logic                  clk,
    input  logic                  rst_b,

    // Host register port
    input  wdt_reg_pkg::reg_req_t req,
    output wdt_reg_pkg::reg_rsp_t rsp,

    // Interrupt pulses and sticky fatal
    output logic                  t1_irq,
    output logic                  t2_irq,
    output logic                  fatal
);

    // Control from registers to timers
    wdt_pkg::wdt_ctrl_t   ctrl;

    // Timer status back for reads
    wdt_pkg::wdt_status_t status;

    wdt_regs wdt_regs_inst (
        .clk    (clk),
        .rst_b  (rst_b),
        .req    (req),
        .rsp    (rsp),
        .status (status),
        .ctrl   (ctrl)
    );

    wdt_unit wdt_unit_inst (
        .clk    (clk),
        .rst_b  (rst_b),
        .ctrl   (ctrl),
        .status (status),
        .t1_irq (t1_irq),
        .t2_irq (t2_irq)
    );

    // Fatal goes straight out
    assign fatal = status.fatal;

endmodule

//--- logic/wdt_regs.sv
`timescale 1ns/1ps

// Register block of the watchdog
module wdt_regs (
    input  logic                  clk,
    input  logic                  rst_b,
    input  wdt_reg_pkg::reg_req_t req,
    output wdt_reg_pkg::reg_rsp_t rsp,
    input  wdt_pkg::wdt_status_t  status,
    output wdt_pkg::wdt_ctrl_t    ctrl
);

    // Write data seen through the register layouts
    wdt_reg_pkg::reg_word_u wr_word;
    wdt_reg_pkg::reg_word_u rd_word;

    logic wr_en;
    logic wr_ctrl;
    logic wr_status;
    logic addr_err;

    // Stored control state
    logic t1_en;
    logic t2_en;
    logic t1_restart;
    logic t2_restart;
    logic t1_serviced;
    logic t2_serviced;
    logic [wdt_pkg::period_w-1:0] t1_period;
    logic [wdt_pkg::period_w-1:0] t2_period;

    assign wr_word.raw = req.wdata;

    assign addr_err  = req.addr > wdt_reg_pkg::addr_status;
    assign wr_en     = req.valid & req.write;
    assign wr_ctrl   = wr_en & (req.addr == wdt_reg_pkg::addr_ctrl);
    assign wr_status = wr_en & (req.addr == wdt_reg_pkg::addr_status);

    // Enables and periods, periods come up as all ones
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t1_en     <= 1'b0;
            t2_en     <= 1'b0;
            t1_period <= '1;
            t2_period <= '1;
        end else if (wr_en) begin
            case (req.addr)
                wdt_reg_pkg::addr_ctrl: begin
                    t1_en <= wr_word.ctrl.t1_en;
                    t2_en <= wr_word.ctrl.t2_en;
                end
                wdt_reg_pkg::addr_t1_lo: t1_period[31:0]  <= wr_word.raw;
                wdt_reg_pkg::addr_t1_hi: t1_period[63:32] <= wr_word.raw;
                wdt_reg_pkg::addr_t2_lo: t2_period[31:0]  <= wr_word.raw;
                wdt_reg_pkg::addr_t2_hi: t2_period[63:32] <= wr_word.raw;
                default: ;
            endcase
        end
    end

    // One-cycle strobes in the cycle after the write
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t1_restart  <= 1'b0;
            t2_restart  <= 1'b0;
            t1_serviced <= 1'b0;
            t2_serviced <= 1'b0;
        end else begin
            t1_restart  <= wr_ctrl & wr_word.ctrl.t1_restart;
            t2_restart  <= wr_ctrl & wr_word.ctrl.t2_restart;
            // The fatal bit has no clear path
            t1_serviced <= wr_status & wr_word.status.t1_timeout;
            t2_serviced <= wr_status & wr_word.status.t2_timeout;
        end
    end

    always_comb begin
        ctrl.t1_en       = t1_en;
        ctrl.t2_en       = t2_en;
        ctrl.t1_restart  = t1_restart;
        ctrl.t2_restart  = t2_restart;
        ctrl.t1_serviced = t1_serviced;
        ctrl.t2_serviced = t2_serviced;
        ctrl.t1_period   = t1_period;
        ctrl.t2_period   = t2_period;
    end

    // Read mux, restart bits read back as zero
    always_comb begin
        rd_word.raw = '0;
        case (req.addr)
            wdt_reg_pkg::addr_ctrl: begin
                rd_word.ctrl.t1_en = t1_en;
                rd_word.ctrl.t2_en = t2_en;
            end
            wdt_reg_pkg::addr_t1_lo: rd_word.raw = t1_period[31:0];
            wdt_reg_pkg::addr_t1_hi: rd_word.raw = t1_period[63:32];
            wdt_reg_pkg::addr_t2_lo: rd_word.raw = t2_period[31:0];
            wdt_reg_pkg::addr_t2_hi: rd_word.raw = t2_period[63:32];
            wdt_reg_pkg::addr_status: begin
                rd_word.status.t1_timeout = status.t1_timeout;
                rd_word.status.t2_timeout = status.t2_timeout;
                rd_word.status.fatal      = status.fatal;
            end
            default: ;
        endcase
    end

    // Response handshake, data is zero for writes
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rsp <= '0;
        end else begin
            rsp.valid <= req.valid;
            rsp.err   <= req.valid & addr_err;
            if (req.valid) begin
                rsp.rdata <= req.write ? '0 : rd_word.raw;
            end
        end
    end

    // Fixed one-cycle latency, no stalls
    rsp_latency: assert property (
        @(posedge clk) disable iff (!rst_b)
        req.valid |=> rsp.valid
    ) else $error("missing response one cycle after request");

endmodule

//--- logic/wdt_unit.sv
`timescale 1ns/1ps

// Watchdog timers plus timeout interrupt pulses
module wdt_unit (
    input  logic                 clk,
    input  logic                 rst_b,
    input  wdt_pkg::wdt_ctrl_t   ctrl,
    output wdt_pkg::wdt_status_t status,
    output logic                 t1_irq,
    output logic                 t2_irq
);

    // Timeout flags from the previous cycle
    logic t1_timeout_d;
    logic t2_timeout_d;

    wdt_timer wdt_timer_inst (
        .clk    (clk),
        .rst_b  (rst_b),
        .ctrl   (ctrl),
        .status (status)
    );

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t1_timeout_d <= 1'b0;
            t2_timeout_d <= 1'b0;
        end else begin
            t1_timeout_d <= status.t1_timeout;
            t2_timeout_d <= status.t2_timeout;
        end
    end

    // Pulse in the cycle the timeout rises
    assign t1_irq = status.t1_timeout & ~t1_timeout_d;

    // Cascade mode reports only through fatal, so gate with t2_en
    assign t2_irq = status.t2_timeout & ~t2_timeout_d & ctrl.t2_en;

    // Pulses last one cycle
    t1_irq_pulse: assert property (
        @(posedge clk) disable iff (!rst_b)
        t1_irq |=> !t1_irq
    ) else $error("t1_irq high for more than one cycle");

    t2_irq_pulse: assert property (
        @(posedge clk) disable iff (!rst_b)
        t2_irq |=> !t2_irq
    ) else $error("t2_irq high for more than one cycle");

endmodule

//--- logic/wdt_timer.sv
`timescale 1ns/1ps

// Two watchdog counters with independent and cascade modes
module wdt_timer (
    input  logic                 clk,
    input  logic                 rst_b,
    input  wdt_pkg::wdt_ctrl_t   ctrl,
    output wdt_pkg::wdt_status_t status
);

    logic [wdt_pkg::period_w-1:0] t1_count;
    logic [wdt_pkg::period_w-1:0] t2_count;

    logic t1_counting;
    logic t2_counting;
    logic t1_hit;
    logic t2_hit;
    logic cascade;

    wdt_pkg::wdt_status_t status_q;

    // Timer2 disabled means it backs up timer1
    assign cascade = ~ctrl.t2_en;

    // Timer1 runs until it times out
    assign t1_counting = ctrl.t1_en & ~status_q.t1_timeout;

    // Timer2 follows its enable, or waits for an unserviced timer1 timeout
    always_comb begin
        if (cascade) begin
            t2_counting = status_q.t1_timeout & ~status_q.fatal;
        end else begin
            t2_counting = ctrl.t2_en & ~status_q.t2_timeout;
        end
    end

    // Period reached while running, a restart in the same cycle wins
    assign t1_hit = t1_counting & ~ctrl.t1_restart & (t1_count == ctrl.t1_period);
    assign t2_hit = t2_counting & ~ctrl.t2_restart & (t2_count == ctrl.t2_period);

    // Timer1 counter
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t1_count <= '0;
        end else if (ctrl.t1_restart || !t1_counting) begin
            t1_count <= '0;
        end else begin
            t1_count <= t1_count + 1'b1;
        end
    end

    // Timer2 counter
    // In cascade mode a serviced timer1 timeout stops and clears it
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            t2_count <= '0;
        end else if (ctrl.t2_restart || !t2_counting) begin
            t2_count <= '0;
        end else begin
            t2_count <= t2_count + 1'b1;
        end
    end

    // Sticky timeouts, held until serviced
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            status_q <= '0;
        end else begin
            status_q.t1_timeout <= (status_q.t1_timeout & ~ctrl.t1_serviced) | t1_hit;
            status_q.t2_timeout <= (status_q.t2_timeout & ~ctrl.t2_serviced) | t2_hit;
            // Fatal only from the cascade path, never cleared by software
            status_q.fatal      <= status_q.fatal | (t2_hit & cascade);
        end
    end

    assign status = status_q;

    // Fatal is sticky until reset
    fatal_sticky: assert property (
        @(posedge clk) disable iff (!rst_b)
        status_q.fatal |=> status_q.fatal
    ) else $error("fatal fell outside reset");

    // Independent mode cannot raise fatal
    fatal_indep: assert property (
        @(posedge clk) disable iff (!rst_b)
        (ctrl.t2_en && !status_q.fatal) |=> !status_q.fatal
    ) else $error("fatal rose in independent mode");

endmodule

//--- logic/wdt_reg_pkg.sv
// Register map and register port types of the watchdog
package wdt_reg_pkg;

    // Word address and data widths
    localparam int unsigned reg_addr_w = 4;
    localparam int unsigned reg_data_w = 32;

    // Register word addresses
    localparam logic [reg_addr_w-1:0] addr_ctrl   = 4'd0;
    localparam logic [reg_addr_w-1:0] addr_t1_lo  = 4'd1;
    localparam logic [reg_addr_w-1:0] addr_t1_hi  = 4'd2;
    localparam logic [reg_addr_w-1:0] addr_t2_lo  = 4'd3;
    localparam logic [reg_addr_w-1:0] addr_t2_hi  = 4'd4;
    localparam logic [reg_addr_w-1:0] addr_status = 4'd5;

    // Request from the host, valid for one cycle
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [reg_addr_w-1:0] addr;
        logic [reg_data_w-1:0] wdata;
    } reg_req_t;

    // Response, one cycle after the request
    typedef struct packed {
        logic                  valid;
        logic                  err;
        logic [reg_data_w-1:0] rdata;
    } reg_rsp_t;

    // Control register layout
    typedef struct packed {
        logic [27:0] rsvd;
        logic        t2_restart;
        logic        t1_restart;
        logic        t2_en;
        logic        t1_en;
    } ctrl_word_t;

    // Status register layout, write one to clear the timeouts
    typedef struct packed {
        logic [28:0] rsvd;
        logic        fatal;
        logic        t2_timeout;
        logic        t1_timeout;
    } status_word_t;

    // One data word seen as raw bits, control bits or status bits
    typedef union packed {
        logic [reg_data_w-1:0] raw;
        ctrl_word_t            ctrl;
        status_word_t          status;
    } reg_word_u;

endpackage

//--- logic/wdt_pkg.sv
// Timer-side definitions shared by the watchdog counters and the register block
package wdt_pkg;

    // Timeout period is two 32-bit words
    localparam int unsigned period_w = 64;

    // Control bundle from the register block to the timers
    typedef struct packed {
        // Timer enables, t2_en low selects cascade mode
        logic t1_en;
        logic t2_en;

        // Single-cycle restart strobes
        logic t1_restart;
        logic t2_restart;

        // Single-cycle strobes from a write-one to a status bit
        logic t1_serviced;
        logic t2_serviced;

        // Timeout periods in clk cycles
        logic [period_w-1:0] t1_period;
        logic [period_w-1:0] t2_period;
    } wdt_ctrl_t;

    // Sticky status returned by the timers
    typedef struct packed {
        logic t1_timeout;
        logic t2_timeout;
        // Only set in cascade mode, cleared only by reset
        logic fatal;
    } wdt_status_t;

endpackage
